//--- frame_gen.f
rtl/frame_gen_pkg.sv
rtl/header_if.sv
rtl/header_capture.sv
rtl/header_fifo.sv
rtl/header_serializer.sv
rtl/frame_gen_top.sv
verif/frame_gen_properties.sv
verif/frame_gen_tb.sv

//--- rtl/frame_gen_pkg.sv
/*
 * IPv4 header frame generator shared definitions
 * Header layout, vector types and FSM state encodings
 */
`default_nettype none

package frame_gen_pkg;

    // --------------------
    // Header layout
    // --------------------
    localparam int BYTE_BITS         = 8;
    localparam int HEADER_BYTES      = 20;
    localparam int FIELD_COUNT       = 11;
    localparam int HEADER_FIFO_DEPTH = 2;

    // --------------------
    // Vector types
    // --------------------
    typedef logic [BYTE_BITS-1:0]              byte_t;
    typedef logic [2*BYTE_BITS-1:0]            field16_t;
    typedef logic [4*BYTE_BITS-1:0]            addr_t;

    // Byte 0 sits in the top byte lane
    typedef logic [HEADER_BYTES*BYTE_BITS-1:0] header_t;

    // One user bit per header byte, byte 0 on the MSB
    typedef logic [HEADER_BYTES-1:0]           header_user_t;

    typedef logic [3:0]                        field_index_t;
    typedef logic [4:0]                        byte_index_t;

    // Last byte of each field in the fixed IPv4 layout
    // version/ihl, tos, length, id, flags, offset, ttl, proto, csum, src, dst
    localparam byte_index_t FIELD_LAST_BYTE [FIELD_COUNT] = '{
        5'd0, 5'd1, 5'd3, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd11, 5'd15, 5'd19
    };

    // --------------------
    // FSM states
    // --------------------
    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_PUSH,
        CAP_WAIT
    } capture_state_t;

    typedef enum logic {
        SER_IDLE,
        SER_SEND
    } serializer_state_t;

endpackage

`default_nettype wire

//--- rtl/frame_gen_top.sv
/*
 * IPv4 header frame generator top level
 * Capture stage, two-entry buffer and byte serializer
 */
`timescale 1ns/1ps
`default_nettype none

module frame_gen_top (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        frame_req,
    output logic                        frame_ack,
    input  frame_gen_pkg::byte_t        version_ihl,
    input  frame_gen_pkg::byte_t        tos,
    input  frame_gen_pkg::field16_t     total_length,
    input  frame_gen_pkg::field16_t     identification,
    input  frame_gen_pkg::byte_t        flags_offset_hi,
    input  frame_gen_pkg::byte_t        offset_lo,
    input  frame_gen_pkg::byte_t        ttl,
    input  frame_gen_pkg::byte_t        protocol,
    input  frame_gen_pkg::field16_t     header_checksum,
    input  frame_gen_pkg::addr_t        source_addr,
    input  frame_gen_pkg::addr_t        dest_addr,
    input  frame_gen_pkg::header_user_t header_user,
    output frame_gen_pkg::byte_t        tdata,
    output logic                        tuser,
    output logic                        tvalid,
    output logic                        tlast,
    output frame_gen_pkg::field_index_t tfield,
    input  logic                        tready
);

    header_if capture_to_fifo ();
    header_if fifo_to_serializer ();

    // --------------------
    // Producer
    // --------------------
    header_capture header_capture_inst (
        .clock           (clock),
        .rst_n           (rst_n),
        .frame_req       (frame_req),
        .frame_ack       (frame_ack),
        .version_ihl     (version_ihl),
        .tos             (tos),
        .total_length    (total_length),
        .identification  (identification),
        .flags_offset_hi (flags_offset_hi),
        .offset_lo       (offset_lo),
        .ttl             (ttl),
        .protocol        (protocol),
        .header_checksum (header_checksum),
        .source_addr     (source_addr),
        .dest_addr       (dest_addr),
        .header_user     (header_user),
        .out             (capture_to_fifo.source)
    );

    // --------------------
    // Buffer
    // --------------------
    header_fifo header_fifo_inst (
        .clock (clock),
        .rst_n (rst_n),
        .in    (capture_to_fifo.sink),
        .out   (fifo_to_serializer.source)
    );

    // --------------------
    // Consumer
    // --------------------
    header_serializer header_serializer_inst (
        .clock  (clock),
        .rst_n  (rst_n),
        .in     (fifo_to_serializer.sink),
        .tdata  (tdata),
        .tuser  (tuser),
        .tvalid (tvalid),
        .tlast  (tlast),
        .tfield (tfield),
        .tready (tready)
    );

endmodule

`default_nettype wire

//--- rtl/header_capture.sv
/*
 * Header capture stage
 * Serves the four-phase frame request and packs the fields into one record
 */
`timescale 1ns/1ps
`default_nettype none

module header_capture (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        frame_req,
    output logic                        frame_ack,
    input  frame_gen_pkg::byte_t        version_ihl,
    input  frame_gen_pkg::byte_t        tos,
    input  frame_gen_pkg::field16_t     total_length,
    input  frame_gen_pkg::field16_t     identification,
    input  frame_gen_pkg::byte_t        flags_offset_hi,
    input  frame_gen_pkg::byte_t        offset_lo,
    input  frame_gen_pkg::byte_t        ttl,
    input  frame_gen_pkg::byte_t        protocol,
    input  frame_gen_pkg::field16_t     header_checksum,
    input  frame_gen_pkg::addr_t        source_addr,
    input  frame_gen_pkg::addr_t        dest_addr,
    input  frame_gen_pkg::header_user_t header_user,
    header_if.source                    out
);

    import frame_gen_pkg::*;

    capture_state_t state;
    header_t        header_reg;
    header_user_t   user_reg;

    // --------------------
    // Request FSM
    // --------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= CAP_IDLE;
            frame_ack <= 1'b0;
        end else begin
            case (state)
                CAP_IDLE: begin
                    if (frame_req) begin
                        state <= CAP_PUSH;
                    end
                end
                CAP_PUSH: begin
                    // Buffer took the record, acknowledge the requester
                    if (out.ready) begin
                        state     <= CAP_WAIT;
                        frame_ack <= 1'b1;
                    end
                end
                CAP_WAIT: begin
                    if (!frame_req) begin
                        state     <= CAP_IDLE;
                        frame_ack <= 1'b0;
                    end
                end
                default: begin
                    state     <= CAP_IDLE;
                    frame_ack <= 1'b0;
                end
            endcase
        end
    end

    // Fields in wire order, MSB first
    always_ff @(posedge clock) begin
        if (state == CAP_IDLE && frame_req) begin
            header_reg <= {version_ihl, tos, total_length, identification,
                           flags_offset_hi, offset_lo, ttl, protocol,
                           header_checksum, source_addr, dest_addr};
            user_reg   <= header_user;
        end
    end

    assign out.valid  = (state == CAP_PUSH);
    assign out.header = header_reg;
    assign out.user   = user_reg;

endmodule

`default_nettype wire

//--- rtl/header_fifo.sv
/*
 * Two-entry header buffer
 * Decouples capture from the serializer so a second frame can wait
 */
`timescale 1ns/1ps
`default_nettype none

module header_fifo (
    input  logic     clock,
    input  logic     rst_n,
    header_if.sink   in,
    header_if.source out
);

    import frame_gen_pkg::*;

    localparam int PTR_BITS   = (HEADER_FIFO_DEPTH > 1) ? $clog2(HEADER_FIFO_DEPTH) : 1;
    localparam int COUNT_BITS = $clog2(HEADER_FIFO_DEPTH + 1);

    header_t              header_mem [HEADER_FIFO_DEPTH];
    header_user_t         user_mem   [HEADER_FIFO_DEPTH];
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [COUNT_BITS-1:0] count;
    logic                  push;
    logic                  pop;

    assign push = in.valid && in.ready;
    assign pop  = out.valid && out.ready;

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge clock) begin
        if (push) begin
            header_mem[wr_ptr] <= in.header;
            user_mem[wr_ptr]   <= in.user;
        end
    end

    // Pointers wrap at the buffer depth
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(HEADER_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(HEADER_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, unchanged when push and pop coincide
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // --------------------
    // Handshake outputs
    // --------------------
    assign in.ready   = (count != COUNT_BITS'(HEADER_FIFO_DEPTH));
    assign out.valid  = (count != '0);
    assign out.header = header_mem[rd_ptr];
    assign out.user   = user_mem[rd_ptr];

endmodule

`default_nettype wire

//--- rtl/header_if.sv
/*
 * Header record channel
 * One captured header plus its user bits, valid/ready handshake
 */
`timescale 1ns/1ps
`default_nettype none

interface header_if;

    import frame_gen_pkg::*;

    logic         valid;
    logic         ready;
    header_t      header;
    header_user_t user;

    // Producer side
    modport source (
        output valid,
        output header,
        output user,
        input  ready
    );

    // Consumer side
    modport sink (
        input  valid,
        input  header,
        input  user,
        output ready
    );

endinterface

`default_nettype wire

//--- rtl/header_serializer.sv
/*
 * Header byte serializer
 * Streams a header MSB first with user bit, field index and last marker
 */
`timescale 1ns/1ps
`default_nettype none

module header_serializer (
    input  logic                        clock,
    input  logic                        rst_n,
    header_if.sink                      in,
    output frame_gen_pkg::byte_t        tdata,
    output logic                        tuser,
    output logic                        tvalid,
    output logic                        tlast,
    output frame_gen_pkg::field_index_t tfield,
    input  logic                        tready
);

    import frame_gen_pkg::*;

    serializer_state_t state;
    header_t           hdr_shift;
    header_user_t      user_shift;
    byte_index_t       byte_cnt;
    field_index_t      field_cnt;
    byte_index_t       next_byte;
    logic              beat_taken;
    logic              load;

    assign tvalid     = (state == SER_SEND);
    assign beat_taken = tvalid && tready;

    // Take a new header when idle or as the last beat leaves
    assign in.ready   = (state == SER_IDLE) || (beat_taken && tlast);
    assign load       = in.valid && in.ready;

    assign next_byte  = byte_cnt + 1'b1;
    assign tfield     = field_cnt;

    // --------------------
    // Control
    // --------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SER_IDLE;
            byte_cnt  <= '0;
            field_cnt <= '0;
            tlast     <= 1'b0;
        end else if (load) begin
            state     <= SER_SEND;
            byte_cnt  <= '0;
            field_cnt <= '0;
            tlast     <= 1'b0;
        end else if (beat_taken) begin
            if (tlast) begin
                // Nothing waiting in the buffer
                state <= SER_IDLE;
                tlast <= 1'b0;
            end else begin
                byte_cnt <= next_byte;
                tlast    <= (next_byte == byte_index_t'(HEADER_BYTES - 1));
                // Step to the next field once its last byte went out
                if (byte_cnt == FIELD_LAST_BYTE[field_cnt]) begin
                    field_cnt <= field_cnt + 1'b1;
                end
            end
        end
    end

    // --------------------
    // Payload
    // --------------------
    // Shift registers, the top lane is always the next byte to send
    always_ff @(posedge clock) begin
        if (load) begin
            tdata      <= in.header[HEADER_BYTES*BYTE_BITS-1 -: BYTE_BITS];
            tuser      <= in.user[HEADER_BYTES-1];
            hdr_shift  <= in.header << BYTE_BITS;
            user_shift <= in.user << 1;
        end else if (beat_taken && !tlast) begin
            tdata      <= hdr_shift[HEADER_BYTES*BYTE_BITS-1 -: BYTE_BITS];
            tuser      <= user_shift[HEADER_BYTES-1];
            hdr_shift  <= hdr_shift << BYTE_BITS;
            user_shift <= user_shift << 1;
        end
    end

endmodule

`default_nettype wire

//--- verif/frame_gen_properties.sv
/*
 * Output stream and request handshake assertions, bound into the top level
 */
`timescale 1ns/1ps
`default_nettype none

module frame_gen_properties (
    input logic                        clock,
    input logic                        rst_n,
    input logic                        frame_req,
    input logic                        frame_ack,
    input frame_gen_pkg::byte_t        tdata,
    input logic                        tuser,
    input logic                        tvalid,
    input logic                        tlast,
    input frame_gen_pkg::field_index_t tfield,
    input logic                        tready
);

    int assert_failures = 0;

    // Stalled beat keeps its payload
    hold_on_stall: assert property (@(posedge clock) disable iff (!rst_n)
        tvalid && !tready |=> tvalid && $stable({tdata, tuser, tfield, tlast}))
        else begin
            assert_failures++;
            $error("stream output changed while tready was low");
        end

    last_needs_valid: assert property (@(posedge clock) disable iff (!rst_n)
        tlast |-> tvalid)
        else begin
            assert_failures++;
            $error("tlast high without tvalid");
        end

    ack_needs_req: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(frame_ack) |-> frame_req)
        else begin
            assert_failures++;
            $error("frame_ack rose without frame_req");
        end

    // Ack only drops once the request is gone
    ack_falls_after_req: assert property (@(posedge clock) disable iff (!rst_n)
        $fell(frame_ack) |-> $past(!frame_req))
        else begin
            assert_failures++;
            $error("frame_ack fell while frame_req was still high");
        end

endmodule

bind frame_gen_top frame_gen_properties frame_gen_properties_inst (.*);

`default_nettype wire

//--- verif/frame_gen_tb.sv
/*
 * Testbench for the IPv4 header frame generator
 * Drives four-phase requests and checks every streamed beat
 */
`timescale 1ns/1ps
`default_nettype none

module frame_gen_tb;

    import frame_gen_pkg::*;

    typedef addr_t [FIELD_COUNT-1:0] field_vals_t;
    localparam int TIMEOUT = 2000;

    logic         clock;
    logic         rst_n;
    logic         frame_req;
    logic         frame_ack;
    byte_t        version_ihl;
    byte_t        tos;
    byte_t        flags_offset_hi;
    byte_t        offset_lo;
    byte_t        ttl;
    byte_t        protocol;
    field16_t     total_length;
    field16_t     identification;
    field16_t     header_checksum;
    addr_t        source_addr;
    addr_t        dest_addr;
    header_user_t header_user;
    byte_t        tdata;
    logic         tuser;
    logic         tvalid;
    logic         tlast;
    logic         tready;
    field_index_t tfield;

    integer       seed;
    int           errors = 0;
    int           errors_at_start = 0;
    int           tests_run = 0;
    int           beats_seen = 0;
    int           frames_seen = 0;
    string        test_name = "none";
    logic [1:0]   ready_mode;
    field_vals_t  exp_fields [$];
    header_user_t exp_user [$];
    field_vals_t  cur_fields;
    header_user_t cur_user;
    byte_index_t  beat_idx = '0;

    frame_gen_top frame_gen_top_inst (.*);

    always #20 clock = ~clock;

    // Mode 1 gives random back-pressure and mode 2 stalls the output
    always @(posedge clock) begin
        case (ready_mode)
            2'd1:    tready <= ($random(seed) & 1) != 0;
            2'd2:    tready <= 1'b0;
            default: tready <= 1'b1;
        endcase
    end

    // --------------------
    // Reference model
    // --------------------
    function automatic field_index_t field_of_byte(input byte_index_t idx);
        field_index_t result;
        result = field_index_t'(FIELD_COUNT - 1);
        for (int f = FIELD_COUNT - 1; f >= 0; f--) begin
            if (idx <= FIELD_LAST_BYTE[f])
                result = field_index_t'(f);
        end
        return result;
    endfunction

    // MSB of each field goes out first
    function automatic byte_t header_byte(input field_vals_t fields, input byte_index_t idx);
        field_index_t f;
        int           shift;
        f     = field_of_byte(idx);
        shift = BYTE_BITS * (FIELD_LAST_BYTE[f] - idx);
        return byte_t'(fields[f] >> shift);
    endfunction

    function automatic logic user_bit(input header_user_t user, input byte_index_t idx);
        return user[HEADER_BYTES - 1 - idx];
    endfunction

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_byte(input byte_t expected, input byte_t actual, input string what);
        if (actual !== expected) begin
            $display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(input logic expected, input logic actual, input string what);
        if (actual !== expected) begin
            $display("error %s %s: expected %b, actual %b", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_field(input field_index_t expected, input field_index_t actual,
                               input string what);
        if (actual !== expected) begin
            $display("error %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
            errors++;
        end
    endtask

    // Compares every accepted beat against the reference
    always @(posedge clock) begin
        if (rst_n && tvalid && tready) begin
            if (beat_idx == '0) begin
                if (exp_fields.size() == 0) begin
                    $display("%s: a beat arrived with no frame requested", test_name);
                    errors++;
                end else begin
                    cur_fields = exp_fields.pop_front();
                    cur_user   = exp_user.pop_front();
                end
            end
            check_byte(header_byte(cur_fields, beat_idx), tdata, "tdata");
            check_bit(user_bit(cur_user, beat_idx), tuser, "tuser");
            check_field(field_of_byte(beat_idx), tfield, "tfield");
            check_bit(beat_idx == byte_index_t'(HEADER_BYTES - 1), tlast, "tlast");
            beats_seen++;
            if (beat_idx == byte_index_t'(HEADER_BYTES - 1)) begin
                frames_seen++;
                beat_idx = '0;
            end else begin
                beat_idx = beat_idx + 1'b1;
            end
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    task automatic request_frame(input field_vals_t f, input header_user_t u);
        int waited;
        @(posedge clock);
        version_ihl     <= f[0][7:0];
        tos             <= f[1][7:0];
        total_length    <= f[2][15:0];
        identification  <= f[3][15:0];
        flags_offset_hi <= f[4][7:0];
        offset_lo       <= f[5][7:0];
        ttl             <= f[6][7:0];
        protocol        <= f[7][7:0];
        header_checksum <= f[8][15:0];
        source_addr     <= f[9];
        dest_addr       <= f[10];
        header_user     <= u;
        frame_req       <= 1'b1;
        exp_fields.push_back(f);
        exp_user.push_back(u);
        waited = 0;
        while (!frame_ack && waited < TIMEOUT) begin
            @(posedge clock);
            waited++;
        end
        if (!frame_ack) begin
            $display("%s: timeout, frame_ack never rose", test_name);
            errors++;
        end
        frame_req <= 1'b0;
        waited = 0;
        while (frame_ack && waited < TIMEOUT) begin
            @(posedge clock);
            waited++;
        end
        if (frame_ack) begin
            $display("%s: timeout, frame_ack stayed high after frame_req fell", test_name);
            errors++;
        end
    endtask

    task automatic wait_frames_out();
        int waited;
        waited = 0;
        while ((exp_fields.size() != 0 || beat_idx != '0) && waited < TIMEOUT) begin
            @(posedge clock);
            waited++;
        end
        if (exp_fields.size() != 0 || beat_idx != '0) begin
            $display("%s: timeout, requested frames were not all sent", test_name);
            errors++;
        end
    endtask

    task automatic make_random_frame(output field_vals_t f, output header_user_t u);
        for (int i = 0; i < FIELD_COUNT; i++)
            f[i] = $random(seed);
        u = header_user_t'($random(seed));
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic report_test();
        tests_run++;
        if (errors == errors_at_start)
            $display("test %s: ok", test_name);
        else
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
    endtask

    initial begin
        field_vals_t  f;
        field_vals_t  rand_fields [10];
        header_user_t rand_user [10];
        seed       = 43;
        clock      = 1'b0;
        rst_n      = 1'b0;
        frame_req  = 1'b0;
        tready     = 1'b1;
        ready_mode = 2'd0;
        {version_ihl, tos, total_length, identification, flags_offset_hi, offset_lo} = '0;
        {ttl, protocol, header_checksum, source_addr, dest_addr, header_user} = '0;
        repeat (8) @(posedge clock);
        rst_n <= 1'b1;
        @(posedge clock);

        // Typical IPv4 header values
        start_test("reset_and_order");
        check_bit(1'b0, tvalid, "tvalid after reset");
        check_bit(1'b0, frame_ack, "frame_ack after reset");
        f[0]  = 32'h45;
        f[1]  = 32'h00;
        f[2]  = 32'h0054;
        f[3]  = 32'h1c46;
        f[4]  = 32'h40;
        f[5]  = 32'h00;
        f[6]  = 32'h40;
        f[7]  = 32'h01;
        f[8]  = 32'hb1e6;
        f[9]  = 32'hc0a8_0001;
        f[10] = 32'hc0a8_00c7;
        request_frame(f, '0);
        wait_frames_out();
        report_test();

        start_test("user_bits");
        request_frame(f, 20'hb4e1d);
        wait_frames_out();
        report_test();

        start_test("field_index");
        for (int i = 0; i < FIELD_COUNT; i++)
            f[i] = 32'h1f2e3d4c + i * 32'h01010101;
        request_frame(f, 20'h0f0f0);
        wait_frames_out();
        report_test();

        start_test("random_backpressure");
        for (int i = 0; i < 10; i++)
            make_random_frame(rand_fields[i], rand_user[i]);
        ready_mode <= 2'd1;
        for (int i = 0; i < 10; i++)
            request_frame(rand_fields[i], rand_user[i]);
        wait_frames_out();
        report_test();

        // Second request only fits because of the buffer
        start_test("buffered_requests");
        ready_mode <= 2'd2;
        request_frame(rand_fields[3], rand_user[3]);
        request_frame(rand_fields[7], rand_user[7]);
        check_bit(1'b1, tvalid, "tvalid while stalled");
        check_byte(header_byte(rand_fields[3], '0), tdata, "tdata while stalled");
        ready_mode <= 2'd0;
        wait_frames_out();
        report_test();

        errors = errors + frame_gen_top_inst.frame_gen_properties_inst.assert_failures;
        $display("tests %0d, frames %0d, beats %0d, assertion failures %0d, errors %0d",
                 tests_run, frames_seen, beats_seen,
                 frame_gen_top_inst.frame_gen_properties_inst.assert_failures, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
